//--- rtl/neuron_pkg.sv
`default_nettype none
package neuron_pkg;

    ////////////////////////////////////////
    // pool size
    localparam int NUM_NEURON = 4;
    localparam int NID_W      = 2;

    // vector types
    typedef logic        [31:0] float32_t;
    typedef logic signed [31:0] current_t;
    // potential, 8 fraction bits
    typedef logic signed [17:0] mem_t;
    typedef logic        [15:0] spkid_t;

    localparam logic [NID_W-1:0] LAST_NID = NID_W'(NUM_NEURON - 1);

    ////////////////////////////////////////
    // word addresses on adr[4:2]
    localparam logic [2:0] REG_RATE   = 3'd0;
    localparam logic [2:0] REG_COEF   = 3'd1;
    localparam logic [2:0] REG_CTRL   = 3'd2;
    localparam logic [2:0] REG_PERIOD = 3'd3;
    localparam logic [2:0] REG_GAIN   = 3'd4;
    localparam logic [2:0] REG_SPKCNT = 3'd5;
    localparam logic [2:0] REG_ICUR   = 3'd6;

    ////////////////////////////////////////
    // regular spiking cell, x256 scale
    localparam mem_t IZH_A  = 18'sd5;
    localparam mem_t IZH_B  = 18'sd51;
    localparam mem_t IZH_C  = -18'sd16640;
    localparam mem_t IZH_D  = 18'sd2048;
    localparam mem_t V_PEAK = 18'sd7680;
    localparam mem_t U_REST = mem_t'((int'(IZH_C) * int'(IZH_B)) >>> 8);
    // 0.04 in 1/1024 steps, 5, and 140 at x256
    localparam int IZH_K2 = 41;
    localparam int IZH_K1 = 5;
    localparam int IZH_K0 = 35840;

    // noise source and float constants
    localparam logic [31:0] LFSR_POLY = 32'hA300_0000;
    localparam logic [31:0] LFSR_SEED = 32'h1D87_2B41;
    localparam float32_t    FP_ONE    = 32'h3F80_0000;

    typedef struct packed {
        float32_t rate;
        float32_t coef;
        current_t gain;
        logic     noise_en;
        logic     run;
    } pool_cfg_t;

    typedef struct packed {
        logic   valid;
        spkid_t spkid;
    } spike_evt_t;

    typedef enum logic [1:0] {IDLE, DRIVE, UPDATE} seq_state_t;

endpackage
`default_nettype wire

//--- rtl/lfsr_rng.sv
`timescale 1ns/100ps
`default_nettype none
module lfsr_rng (
    input  logic        neuron_clk,
    input  logic        reset_sim,
    input  logic        next,
    output logic [31:0] rnd
);
    import neuron_pkg::*;

    // galois form, shifts right
    // feedback taps xor'd in when lsb falls out
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            rnd <= LFSR_SEED;
        end else if (next) begin
            if (rnd[0]) begin
                rnd <= {1'b0, rnd[31:1]} ^ LFSR_POLY;
            end else begin
                rnd <= {1'b0, rnd[31:1]};
            end
        end
    end

endmodule
`default_nettype wire

//--- rtl/fp_mult.sv
`timescale 1ns/100ps
`default_nettype none
module fp_mult (
    input  neuron_pkg::float32_t x,
    input  neuron_pkg::float32_t y,
    output neuron_pkg::float32_t p
);
    logic        sign;
    logic [23:0] man_x;
    logic [23:0] man_y;
    logic [47:0] prod;
    logic        norm;
    logic [22:0] man_p;
    logic [9:0]  exp_sum;
    logic        is_zero;
    logic        is_inf;

    assign sign = x[31] ^ y[31];

    // hidden one restored
    assign man_x = {1'b1, x[22:0]};
    assign man_y = {1'b1, y[22:0]};
    assign prod  = man_x * man_y;

    // product in [1,4), one bit of normalization at most
    assign norm  = prod[47];
    // low bits dropped, truncation
    assign man_p = norm ? prod[46:24] : prod[45:23];

    // 10 bits so underflow shows in bit 9
    assign exp_sum = 10'(x[30:23]) + 10'(y[30:23]) + 10'(norm) - 10'd127;

    // exponent 0 operand counts as zero, denormals ignored
    assign is_zero = (x[30:23] == 8'd0) || (y[30:23] == 8'd0) ||
                     exp_sum[9] || (exp_sum == 10'd0);
    assign is_inf  = !exp_sum[9] && (exp_sum >= 10'd255);

    always_comb begin
        if (is_zero) begin
            p = {sign, 31'd0};
        end else if (is_inf) begin
            // clamp to infinity
            p = {sign, 8'hFF, 23'd0};
        end else begin
            p = {sign, exp_sum[7:0], man_p};
        end
    end

endmodule
`default_nettype wire

//--- rtl/fp_floor_int.sv
`timescale 1ns/100ps
`default_nettype none
module fp_floor_int (
    input  neuron_pkg::float32_t f,
    output neuron_pkg::current_t i
);
    logic [8:0]  unb;
    logic [54:0] fixed;
    logic [31:0] mag;
    logic        frac;

    // unbiased exponent, bit 8 set when below zero
    assign unb = {1'b0, f[30:23]} - 9'd127;

    // mantissa with 23 fraction bits, moved up by the exponent
    assign fixed = {31'd0, 1'b1, f[22:0]} << unb[4:0];
    assign mag   = fixed[54:23];
    assign frac  = |fixed[22:0];

    always_comb begin
        if (unb[8]) begin
            // |f| below one
            if (f[31] && (f[30:23] != 8'd0)) begin
                i = -32'sd1;
            end else begin
                i = '0;
            end
        end else if (unb >= 9'd31) begin
            // out of range, clamp
            i = f[31] ? 32'sh8000_0000 : 32'sh7FFF_FFFF;
        end else if (f[31]) begin
            // negative, floor goes one further down on a fraction
            i = -$signed(mag) - (frac ? 32'sd1 : 32'sd0);
        end else begin
            i = $signed(mag);
        end
    end

endmodule
`default_nettype wire

//--- rtl/ia_drive.sv
`timescale 1ns/100ps
`default_nettype none
module ia_drive (
    input  logic                             neuron_clk,
    input  logic                             reset_sim,
    input  logic                             in_valid,
    input  logic [neuron_pkg::NID_W-1:0]     in_nid,
    input  neuron_pkg::float32_t             rate,
    input  neuron_pkg::float32_t             coef,
    input  neuron_pkg::float32_t             noise,
    input  neuron_pkg::current_t             gain,
    input  logic                             noise_en,
    output logic                             out_valid,
    output logic [neuron_pkg::NID_W-1:0]     out_nid,
    output neuron_pkg::current_t             current
);
    import neuron_pkg::*;

    float32_t             noise_f;
    float32_t             rate_noisy;
    float32_t             s1_prod;
    float32_t             scaled;
    current_t             syn_int;
    logic                 s1_valid;
    logic [NID_W-1:0]     s1_nid;

    // noise factor in [1,2), exponent 127, 20 random mantissa bits
    assign noise_f = noise_en ? {9'h07F, noise[19:0], 3'b000} : FP_ONE;

    ////////////////////////////////////////
    // stage 1, rate x noise
    fp_mult u_mult_noise (
        .x (rate),
        .y (noise_f),
        .p (rate_noisy)
    );

    ////////////////////////////////////////
    // stage 2, floor(x coef) x gain
    fp_mult u_mult_coef (
        .x (s1_prod),
        .y (coef),
        .p (scaled)
    );

    fp_floor_int u_floor (
        .f (scaled),
        .i (syn_int)
    );

    // valid travels with the data
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge neuron_clk) begin
        s1_prod <= rate_noisy;
        s1_nid  <= in_nid;
        out_nid <= s1_nid;
        // low 32 bits of the signed product
        current <= syn_int * gain;
    end

endmodule
`default_nettype wire

//--- rtl/izh_neuron_mux.sv
`timescale 1ns/100ps
`default_nettype none
module izh_neuron_mux (
    input  logic                             neuron_clk,
    input  logic                             reset_sim,
    input  logic                             in_valid,
    input  logic [neuron_pkg::NID_W-1:0]     in_nid,
    input  neuron_pkg::current_t             current,
    output neuron_pkg::spike_evt_t           evt
);
    import neuron_pkg::*;

    mem_t               v_mem [NUM_NEURON];
    mem_t               u_mem [NUM_NEURON];
    mem_t               v_cur;
    mem_t               u_cur;
    mem_t               v_new;
    mem_t               u_new;
    current_t           i_sat;
    logic signed [39:0] i_ext;
    logic signed [39:0] v_sq;
    logic signed [39:0] dv;
    logic signed [39:0] bv;
    logic signed [39:0] du;
    logic               fire;

    function automatic mem_t sat_mem(input logic signed [39:0] x);
        if (x > 40'sd131071) begin
            sat_mem = 18'sd131071;
        end else if (x < -40'sd131071) begin
            sat_mem = mem_t'({1'b1, 17'd0});
        end else begin
            sat_mem = mem_t'(x);
        end
    endfunction

    // state of the addressed cell
    assign v_cur = v_mem[in_nid];
    assign u_cur = u_mem[in_nid];

    // clamp so that I x256 still fits mem_t
    always_comb begin
        if (current > 32'sd511) begin
            i_sat = 32'sd511;
        end else if (current < -32'sd511) begin
            i_sat = -32'sd511;
        end else begin
            i_sat = current;
        end
    end
    assign i_ext = 40'(i_sat) <<< 8;

    ////////////////////////////////////////
    // euler step, dt = 1
    // dv = 0.04 v^2 + 5 v + 140 - u + I
    assign v_sq = (40'(v_cur) * 40'(v_cur)) >>> 8;
    assign dv   = ((v_sq * 40'(IZH_K2)) >>> 10) + 40'(v_cur) * 40'(IZH_K1)
                + 40'(IZH_K0) - 40'(u_cur) + i_ext;
    // du = a (b v - u)
    assign bv   = (40'(v_cur) * 40'(IZH_B)) >>> 8;
    assign du   = ((bv - 40'(u_cur)) * 40'(IZH_A)) >>> 8;

    assign v_new = sat_mem(40'(v_cur) + dv);
    assign u_new = sat_mem(40'(u_cur) + du);
    assign fire  = (v_new >= V_PEAK);

    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            // all cells at rest
            for (int n = 0; n < NUM_NEURON; n++) begin
                v_mem[n] <= IZH_C;
                u_mem[n] <= U_REST;
            end
            evt <= '0;
        end else begin
            if (in_valid) begin
                if (fire) begin
                    // after-spike reset
                    v_mem[in_nid] <= IZH_C;
                    u_mem[in_nid] <= sat_mem(40'(u_new) + 40'(IZH_D));
                end else begin
                    v_mem[in_nid] <= v_new;
                    u_mem[in_nid] <= u_new;
                end
            end
            // spike one cycle after the update request
            evt.valid <= in_valid && fire;
            evt.spkid <= spkid_t'(in_nid);
        end
    end

endmodule
`default_nettype wire

//--- rtl/neuron_pool.sv
`timescale 1ns/100ps
`default_nettype none
module neuron_pool (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    input  neuron_pkg::pool_cfg_t   cfg,
    input  logic                    step,
    output neuron_pkg::spike_evt_t  evt,
    output neuron_pkg::current_t    last_current
);
    import neuron_pkg::*;

    seq_state_t         state;
    logic [NID_W-1:0]   nid_q;
    logic               req_valid;
    logic [31:0]        rnd;
    logic               drv_valid;
    logic [NID_W-1:0]   drv_nid;
    current_t           drv_current;

    // one request per cycle while walking the cells
    assign req_valid = (state == DRIVE);

    lfsr_rng u_rng (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .next       (req_valid),
        .rnd        (rnd)
    );

    ia_drive u_drive (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .in_valid   (req_valid),
        .in_nid     (nid_q),
        .rate       (cfg.rate),
        .coef       (cfg.coef),
        .noise      (rnd),
        .gain       (cfg.gain),
        .noise_en   (cfg.noise_en),
        .out_valid  (drv_valid),
        .out_nid    (drv_nid),
        .current    (drv_current)
    );

    izh_neuron_mux u_core (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .in_valid   (drv_valid),
        .in_nid     (drv_nid),
        .current    (drv_current),
        .evt        (evt)
    );

    ////////////////////////////////////////
    // step sequencer
    // steps seen outside IDLE are lost
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            state        <= IDLE;
            nid_q        <= '0;
            last_current <= '0;
        end else begin
            case (state)
                IDLE: begin
                    nid_q <= '0;
                    if (step) begin
                        state <= DRIVE;
                    end
                end
                DRIVE: begin
                    nid_q <= nid_q + 1'b1;
                    if (nid_q == LAST_NID) begin
                        state <= UPDATE;
                    end
                end
                // wait for the last cell to leave the pipe
                UPDATE: begin
                    if (drv_valid && (drv_nid == LAST_NID)) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (drv_valid) begin
                last_current <= drv_current;
            end
        end
    end

endmodule
`default_nettype wire

//--- rtl/pool_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none
module pool_wb_regs (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [4:2]              adr,
    input  logic [31:0]             dat_w,
    input  logic [3:0]              sel,
    output logic [31:0]             dat_r,
    output logic                    ack,
    output neuron_pkg::pool_cfg_t   cfg,
    output logic                    step,
    input  neuron_pkg::spike_evt_t  evt,
    input  neuron_pkg::current_t    last_current
);
    import neuron_pkg::*;

    logic [31:0] period_q;
    logic [31:0] period_cnt;
    logic [31:0] spkcnt_q;
    logic [31:0] ctrl_w;
    logic        access;
    logic        wr_en;

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  lanes);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one ack per transfer, not while ack is already high
    assign access = cyc && stb && !ack;
    assign wr_en  = access && we;
    assign ctrl_w = merge_lanes({30'd0, cfg.noise_en, cfg.run}, dat_w, sel);

    ////////////////////////////////////////
    // register writes and ack
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            ack      <= 1'b0;
            cfg      <= '0;
            period_q <= '0;
        end else begin
            ack <= access;
            if (wr_en) begin
                case (adr)
                    REG_RATE:   cfg.rate <= merge_lanes(cfg.rate, dat_w, sel);
                    REG_COEF:   cfg.coef <= merge_lanes(cfg.coef, dat_w, sel);
                    REG_GAIN:   cfg.gain <= merge_lanes(cfg.gain, dat_w, sel);
                    REG_PERIOD: period_q <= merge_lanes(period_q, dat_w, sel);
                    REG_CTRL: begin
                        cfg.run      <= ctrl_w[0];
                        cfg.noise_en <= ctrl_w[1];
                    end
                    default: ;
                endcase
            end
        end
    end

    // read data lands with ack
    always_ff @(posedge neuron_clk) begin
        if (access) begin
            case (adr)
                REG_RATE:   dat_r <= cfg.rate;
                REG_COEF:   dat_r <= cfg.coef;
                REG_CTRL:   dat_r <= {30'd0, cfg.noise_en, cfg.run};
                REG_PERIOD: dat_r <= period_q;
                REG_GAIN:   dat_r <= cfg.gain;
                REG_SPKCNT: dat_r <= spkcnt_q;
                REG_ICUR:   dat_r <= last_current;
                default:    dat_r <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // step timer and spike count
    // reload at zero gives a pulse every PERIOD+1 cycles
    always_ff @(posedge neuron_clk or posedge reset_sim) begin
        if (reset_sim) begin
            period_cnt <= '0;
            step       <= 1'b0;
            spkcnt_q   <= '0;
        end else begin
            if (!cfg.run) begin
                period_cnt <= period_q;
                step       <= 1'b0;
            end else if (period_cnt == 32'd0) begin
                period_cnt <= period_q;
                step       <= 1'b1;
            end else begin
                period_cnt <= period_cnt - 32'd1;
                step       <= 1'b0;
            end
            // any write clears the count
            if (wr_en && (adr == REG_SPKCNT)) begin
                spkcnt_q <= '0;
            end else if (evt.valid) begin
                spkcnt_q <= spkcnt_q + 32'd1;
            end
        end
    end

endmodule
`default_nettype wire

//--- rtl/neuron_pool_top.sv
`timescale 1ns/100ps
`default_nettype none
module neuron_pool_top (
    input  logic                    neuron_clk,
    input  logic                    reset_sim,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [4:2]              adr,
    input  logic [31:0]             dat_w,
    input  logic [3:0]              sel,
    output logic [31:0]             dat_r,
    output logic                    ack,
    output neuron_pkg::spike_evt_t  spike
);
    import neuron_pkg::*;

    pool_cfg_t cfg;
    logic      step;
    current_t  last_current;

    // bus side, config and step timer
    pool_wb_regs u_regs (
        .neuron_clk   (neuron_clk),
        .reset_sim    (reset_sim),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .sel          (sel),
        .dat_r        (dat_r),
        .ack          (ack),
        .cfg          (cfg),
        .step         (step),
        .evt          (spike),
        .last_current (last_current)
    );

    // spike events also feed the counter
    neuron_pool u_pool (
        .neuron_clk   (neuron_clk),
        .reset_sim    (reset_sim),
        .cfg          (cfg),
        .step         (step),
        .evt          (spike),
        .last_current (last_current)
    );

endmodule
`default_nettype wire

//--- sim/tb_neuron_pool.sv
`timescale 1ns/100ps
`default_nettype none
module tb_neuron_pool;
    import neuron_pkg::*;

    // step timer reload value gives one step every 8 cycles
    localparam logic [31:0] STEP_PERIOD  = 32'd7;
    localparam int          STEP_CYCLES  = 8;
    // pipeline empties 7 cycles after the last step pulse
    localparam int          DRAIN_CYCLES = 12;
    // about 120 steps of 8 cycles plus drains and bus traffic come to roughly 1300 cycles
    localparam int          TIMEOUT_CYCLES = 4000;

    logic        neuron_clk;
    logic        reset_sim;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [4:2]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;
    spike_evt_t  spike;

    integer      seed;
    int          cycle_count = 0;
    int          spike_total = 0;
    // high while no spike is allowed
    logic        quiet;

    neuron_pool_top DUT (
        .neuron_clk (neuron_clk),
        .reset_sim  (reset_sim),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .sel        (sel),
        .dat_r      (dat_r),
        .ack        (ack),
        .spike      (spike)
    );

    initial begin
        neuron_clk = 1'b0;
        forever #10 neuron_clk = ~neuron_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // monitors and bus/spike properties
    always @(posedge neuron_clk) begin
        cycle_count++;
        if (!reset_sim && spike.valid) begin
            spike_total++;
        end
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ack_needs_stb: assert property (@(posedge neuron_clk) disable iff (reset_sim)
        ack |-> stb) else abort_run("ack seen without stb");
    spike_id_range: assert property (@(posedge neuron_clk) disable iff (reset_sim)
        spike.valid |-> (spike.spkid < 16'(NUM_NEURON)))
        else abort_run("spike id outside the pool");
    no_spike_when_quiet: assert property (@(posedge neuron_clk) disable iff (reset_sim)
        quiet |-> !spike.valid) else abort_run("spike while the pool should be silent");

    ////////////////////////////////////////
    // wishbone master
    task automatic wb_transfer(input logic wr, input logic [2:0] a,
                               input logic [31:0] wd, output logic [31:0] rd);
        int waited;
        waited = 0;
        @(posedge neuron_clk);
        #2;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        sel   = 4'hF;
        // ack is registered so it is looked at mid-cycle
        @(negedge neuron_clk);
        while (!ack) begin
            waited++;
            if (waited > 8) begin
                abort_run($sformatf("no ack from register %0d", a));
            end
            @(negedge neuron_clk);
        end
        rd = dat_r;
        // release after the edge that sampled ack
        @(posedge neuron_clk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] a, input logic [31:0] d);
        logic [31:0] unused_rd;
        wb_transfer(1'b1, a, d, unused_rd);
    endtask

    task automatic read_reg(input logic [2:0] a, output logic [31:0] d);
        wb_transfer(1'b0, a, 32'd0, d);
    endtask

    ////////////////////////////////////////
    // checks and helpers
    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual == expected) else abort_run($sformatf(
            "error %s: expected %0d (0x%08h) actual %0d (0x%08h)",
            name, $signed(expected), expected, $signed(actual), actual));
    endtask

    task automatic range_check(input string name, input real lo, input real hi,
                               input logic [31:0] actual);
        real a;
        a = $itor($signed(actual));
        assert ((a >= lo) && (a < hi)) else abort_run($sformatf(
            "error %s: expected %0.2f <= value < %0.2f actual %0d",
            name, lo, hi, $signed(actual)));
    endtask

    task automatic ensure(input bit cond, input string what);
        assert (cond) else abort_run(what);
    endtask

    // floor(rate x coef) x gain with noise at 1.0
    function automatic int floor_current(input real r, input real c, input int g);
        return $rtoi($floor(r * c)) * g;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge neuron_clk);
    endtask

    task automatic readback(input string name, input logic [2:0] a);
        logic [31:0] val;
        logic [31:0] rd;
        val = $random(seed);
        write_reg(a, val);
        read_reg(a, rd);
        compare_value(name, val, rd);
    endtask

    task automatic drive_config(input logic [31:0] rate, input logic [31:0] coef,
                                input logic [31:0] gain);
        write_reg(REG_RATE, rate);
        write_reg(REG_COEF, coef);
        write_reg(REG_GAIN, gain);
    endtask

    // run for about n steps before stopping and letting the pipe drain
    task automatic run_steps(input int n, input logic noise);
        write_reg(REG_CTRL, {30'd0, noise, 1'b1});
        idle_cycles(n * STEP_CYCLES);
        write_reg(REG_CTRL, {30'd0, noise, 1'b0});
        idle_cycles(DRAIN_CYCLES);
    endtask

    ////////////////////////////////////////
    // test sequence
    initial begin
        logic [31:0] rd;
        int          base;
        seed      = 32'hd92457c7;
        reset_sim = 1'b1;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        sel       = '0;
        quiet     = 1'b0;
        repeat (3) @(posedge neuron_clk);
        #2;
        reset_sim = 1'b0;

        // register readback and counters clear after reset
        readback("rate readback", REG_RATE);
        readback("coef readback", REG_COEF);
        readback("period readback", REG_PERIOD);
        readback("gain readback", REG_GAIN);
        read_reg(REG_SPKCNT, rd);
        compare_value("spkcnt after reset", 32'd0, rd);
        read_reg(REG_ICUR, rd);
        compare_value("icur after reset", 32'd0, rd);

        // with gain 0 the cells stay at rest
        write_reg(REG_GAIN, 32'd0);
        write_reg(REG_PERIOD, STEP_PERIOD);
        quiet = 1'b1;
        run_steps(50, 1'b0);
        quiet = 1'b0;
        read_reg(REG_SPKCNT, rd);
        compare_value("resting spkcnt", 32'd0, rd);

        // exact products with noise off
        drive_config(32'h41A0_0000, 32'h3F00_0000, 32'd3);
        run_steps(3, 1'b0);
        read_reg(REG_ICUR, rd);
        compare_value("drive 20.0 x 0.5 x 3", floor_current(20.0, 0.5, 3), rd);
        drive_config(32'h40F8_0000, 32'h4000_0000, 32'd1);
        run_steps(3, 1'b0);
        read_reg(REG_ICUR, rd);
        compare_value("drive 7.75 x 2.0 x 1", floor_current(7.75, 2.0, 1), rd);

        // strong drive of 100.0 x 1.0 x 10
        write_reg(REG_SPKCNT, 32'd0);
        base = spike_total;
        drive_config(32'h42C8_0000, 32'h3F80_0000, 32'd10);
        run_steps(30, 1'b0);
        read_reg(REG_SPKCNT, rd);
        ensure(rd != 32'd0, "no spikes under strong drive");
        compare_value("spkcnt vs spike pulses", 32'(spike_total - base), rd);

        // noise on with 12.5 x 1.5 x 2
        drive_config(32'h4148_0000, 32'h3FC0_0000, 32'd2);
        write_reg(REG_CTRL, 32'd3);
        idle_cycles(2 * STEP_CYCLES);
        for (int k = 0; k < 12; k++) begin
            read_reg(REG_ICUR, rd);
            range_check("noise bounds", floor_current(12.5, 1.5, 2),
                        2.0 * 12.5 * 1.5 * 2.0, rd);
            idle_cycles(1 + ($unsigned($random(seed)) % 7));
        end
        write_reg(REG_CTRL, 32'd0);
        idle_cycles(DRAIN_CYCLES);

        // counter clear and then nothing after run drops
        drive_config(32'h42C8_0000, 32'h3F80_0000, 32'd10);
        run_steps(20, 1'b0);
        read_reg(REG_SPKCNT, rd);
        ensure(rd != 32'd0, "spike counter idle before the clear");
        write_reg(REG_SPKCNT, 32'hFFFF_FFFF);
        read_reg(REG_SPKCNT, rd);
        compare_value("spkcnt clear", 32'd0, rd);
        quiet = 1'b1;
        idle_cycles(10 * STEP_CYCLES);
        quiet = 1'b0;
        read_reg(REG_SPKCNT, rd);
        compare_value("spkcnt after stop", 32'd0, rd);

        $display("Verification passed");
        $finish;
    end

endmodule
`default_nettype wire

//--- sim.f
rtl/neuron_pkg.sv
rtl/lfsr_rng.sv
rtl/fp_mult.sv
rtl/fp_floor_int.sv
rtl/ia_drive.sv
rtl/izh_neuron_mux.sv
rtl/neuron_pool.sv
rtl/pool_wb_regs.sv
rtl/neuron_pool_top.sv
sim/tb_neuron_pool.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_neuron_pool --Mdir obj_dir \
    -o tb_neuron_pool -f sim.f > build.log 2>&1 &&
{ ./obj_dir/tb_neuron_pool > sim.log 2>&1; cat sim.log; } &&
grep -q "Verification passed" sim.log &&
echo "simulation run ok" ||
{ echo "simulation run failed, see build.log and sim.log"; exit 1; }
